/* bench/board_checker.sv */
/*
 * Watches the board outputs: scan order, displayed ADC value, LED
 * state after key events, SPI replies and the state right after reset.
 * Event inputs come from the testbench, sampled on the rising clock edge.
 */
`timescale 1ns/10ps
`default_nettype none

module board_checker (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic [7:0]                led,
	input  display_pkg::seg_pattern_t seg_number,
	input  logic [7:0]                seg_choice,
	input  logic                      sda_oe,
	input  logic                      miso,
	input  logic                      adc_log,
	input  board_pkg::adc_byte_t      adc_byte,
	input  logic                      press_done,
	input  logic                      release_done,
	input  logic [1:0]                key_idx,
	input  logic                      spi_done,
	input  logic                      spi_abort,
	input  board_pkg::spi_byte_t      spi_sent,
	input  board_pkg::spi_byte_t      spi_got,
	output logic                      busy,
	output int                        errors
);

	display_pkg::digit_frame_t mframe;
	logic [7:0] exp_led;
	board_pkg::spi_byte_t exp_reply;
	int win_wait, win_left, run_len, last_idx, idx;
	logic first_run, reset_seen;

	// dash on the left, value right-aligned with no leading zeros
	function automatic display_pkg::digit_frame_t frame_for(input board_pkg::adc_byte_t v);
		display_pkg::digit_frame_t f;
		int n;
		int pos;
		f = {display_pkg::DIGIT_DASH, {7{display_pkg::DIGIT_BLANK}}};
		n = int'(v);
		pos = 0;
		do begin
			f[pos*4 +: 4] = 4'(n % 10); // lowest decimal digit goes rightmost
			n = n / 10;
			pos++;
		end while (n != 0);
		return f;
	endfunction

	// selected digit, -1 unless exactly one select is low
	function automatic int sel_index(input logic [7:0] sel);
		int n;
		int pos;
		n = 0;
		pos = -1;
		for (int i = 0; i < 8; i++) begin
			if (!sel[i]) begin
				n++;
				pos = i;
			end
		end
		return (n == 1) ? pos : -1;
	endfunction

	task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
		errors++;
	endtask

	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			errors = 0;
			mframe = {display_pkg::DIGIT_DASH, {7{display_pkg::DIGIT_BLANK}}};
			win_wait = 2; // first scan shows the reset frame
			win_left = 8 * display_pkg::SCAN_CYCLES;
			exp_led = 8'h00;
			exp_reply = 8'h02;
			first_run = 1'b1;
			reset_seen = 1'b0;
			last_idx = 0;
			run_len = 0;
		end else begin
			if (!reset_seen) begin
				reset_seen = 1'b1;
				if (led != 8'h00) report("led", 32'h0, 32'(led));
				if (miso != 1'b1) report("miso", 32'h1, 32'(miso));
				if (sda_oe != 1'b0) report("sda_oe", 32'h0, 32'(sda_oe));
			end
			idx = sel_index(seg_choice);
			if (idx < 0) begin
				$display("at %0t seg_choice %0h does not select exactly one digit",
					$time, seg_choice);
				errors++;
			end else if (idx != last_idx) begin
				if (!first_run) begin
					if (idx != (last_idx + 1) % 8) begin
						report("seg_choice digit", 32'((last_idx + 1) % 8), 32'(idx));
					end
					if (run_len != display_pkg::SCAN_CYCLES) begin
						report("seg_choice slot length", display_pkg::SCAN_CYCLES,
							32'(run_len));
					end
				end
				first_run = 1'b0;
				run_len = 1;
				last_idx = idx;
			end else begin
				run_len++;
			end
			if (adc_log) begin
				mframe = frame_for(adc_byte);
				win_wait = 20; // STOP tail, format and scan register
				win_left = 8 * display_pkg::SCAN_CYCLES;
			end else if (win_wait > 0) begin
				win_wait--;
			end else if (idx >= 0) begin
				// display holds the last logged value until the next one
				if (seg_number != display_pkg::GLYPH[mframe[idx*4 +: 4]]) begin
					report("seg_number", 32'(display_pkg::GLYPH[mframe[idx*4 +: 4]]),
						32'(seg_number));
				end
				if (win_left > 0) win_left--;
			end
			if (press_done) begin
				exp_led[key_idx] = ~exp_led[key_idx];
				exp_led[7:4] = exp_led[7:4] + 4'd1;
				if (led != exp_led) report("led", 32'(exp_led), 32'(led));
			end
			if (release_done && led != exp_led) report("led", 32'(exp_led), 32'(led));
			if (spi_done) begin
				if (!spi_abort) begin
					if (spi_got != exp_reply) report("miso byte", 32'(exp_reply), 32'(spi_got));
					exp_reply = spi_sent + 8'(board_pkg::SPI_REPLY_OFFSET);
				end
			end
		end
		busy = (win_wait > 0) || (win_left > 0);
	end

endmodule

`default_nettype wire

/* bench/board_tb.sv */
/*
 * Testbench for board_top: clock and reset, an I2C ADC device model,
 * an SPI master and bouncing keys, all driven from LFSR random bits.
 */
`timescale 1ns/10ps
`default_nettype none

module board_tb;

	localparam logic [31:0] SEED = 32'hffafd8db;

	logic sys_clk = 1'b0;
	logic sda_in = 1'b1; // bus idles released
	logic sys_rst_n, scl_in, cs, sclk, mosi;
	logic [3:0] key_in;
	logic [7:0] led, seg_choice;
	display_pkg::seg_pattern_t seg_number;
	logic scl, sda_oe, miso;
	logic adc_log, press_done, release_done, spi_done, spi_abort, busy;
	logic [1:0] key_idx;
	board_pkg::adc_byte_t adc_byte;
	board_pkg::spi_byte_t spi_sent, spi_got;
	int errors, tb_errors, adc_count, bitn, addr_cnt, withhold_at, t;
	logic [31:0] main_lfsr, i2c_lfsr, r, i2c_bits;
	logic prev_scl, prev_sda, bus_sda, slave_low, ack;
	logic first_byte, sending, rd_next, data_done, withheld;
	logic [7:0] shreg, rd_data;

	board_top DUT (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .key_in(key_in), .scl_in(scl_in),
		.sda_in(sda_in), .cs(cs), .sclk(sclk), .mosi(mosi), .led(led),
		.seg_number(seg_number), .seg_choice(seg_choice), .scl(scl),
		.sda_oe(sda_oe), .miso(miso)
	);

	board_checker u_checker (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .led(led), .seg_number(seg_number),
		.seg_choice(seg_choice), .sda_oe(sda_oe), .miso(miso), .adc_log(adc_log),
		.adc_byte(adc_byte), .press_done(press_done), .release_done(release_done),
		.key_idx(key_idx), .spi_done(spi_done), .spi_abort(spi_abort),
		.spi_sent(spi_sent), .spi_got(spi_got), .busy(busy), .errors(errors)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0); // taps 32,22,2,1
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(input int n, inout logic [31:0] st, output logic [31:0] v);
		v = '0;
		repeat (n) begin
			v = {v[30:0], st[0]};
			st = lfsr_next(st);
		end
	endtask

	initial begin
		forever #4 sys_clk = ~sys_clk;
	end

	// I2C ADC device, follows scl and the wired-AND SDA on each falling edge
	always @(negedge sys_clk) begin
		adc_log = 1'b0;
		if (!sys_rst_n) begin
			i2c_lfsr = SEED;
			take_bits(2, i2c_lfsr, i2c_bits);
			withhold_at = 1 + int'(i2c_bits[1:0]); // one address byte gets no ACK
			{prev_scl, prev_sda, slave_low, withheld} = 4'b1100;
			{first_byte, sending, rd_next, data_done} = 4'b0000;
			bitn = 0;
			addr_cnt = 0;
			adc_count = 0;
			shreg = 8'h00;
			rd_data = 8'h00;
		end else begin
			bus_sda = ~(sda_oe | slave_low);
			if (scl && prev_scl && prev_sda && !bus_sda) begin // START
				bitn = 0;
				first_byte = 1'b1;
				sending = 1'b0;
				rd_next = 1'b0;
			end else if (scl && prev_scl && !prev_sda && bus_sda) begin // STOP
				if (data_done) begin
					adc_byte = rd_data;
					adc_log = 1'b1;
					adc_count++;
				end
				data_done = 1'b0;
				sending = 1'b0;
				bitn = 0;
			end else if (scl && !prev_scl) begin
				if (bitn < 8) shreg = {shreg[6:0], bus_sda};
				bitn++;
			end else if (!scl && prev_scl) begin
				if (bitn == 8 && !sending) begin
					if (first_byte) begin
						addr_cnt++;
						ack = (shreg[7:1] == 7'h54) && (addr_cnt != withhold_at);
						if (shreg[7:1] == 7'h54 && addr_cnt == withhold_at) withheld = 1'b1;
						rd_next = ack && shreg[0];
					end else begin
						ack = (shreg == 8'h00);
					end
					slave_low = ack;
				end else if (bitn == 8) begin
					slave_low = 1'b0; // master NACK slot
				end else if (bitn == 9) begin
					bitn = 0;
					first_byte = 1'b0;
					slave_low = 1'b0;
					if (sending) begin
						sending = 1'b0;
						data_done = 1'b1;
					end else if (rd_next) begin
						rd_next = 1'b0;
						sending = 1'b1;
						take_bits(8, i2c_lfsr, i2c_bits);
						rd_data = i2c_bits[7:0];
						slave_low = ~rd_data[7];
					end
				end else if (sending && bitn >= 1) begin
					slave_low = ~rd_data[7-bitn];
				end
			end
			prev_scl = scl;
			prev_sda = bus_sda;
		end
		sda_in = ~(sda_oe | slave_low);
	end

	// press with bounce, wait for the LED, then release with bounce
	task automatic key_cycle(input int k);
		logic [31:0] v;
		logic [7:0] old_led;
		int nb;
		int w;
		for (int phase = 0; phase < 2; phase++) begin
			take_bits(4, main_lfsr, v);
			nb = int'(v[3:0]) % 9;
			for (int b = 0; b < nb; b++) begin
				key_in[k] = ~key_in[k];
				take_bits(4, main_lfsr, v);
				repeat (1 + int'(v[3:0])) @(negedge sys_clk); // well under debounce
			end
			key_in[k] = (phase == 1);
			if (phase == 0) begin
				old_led = led;
				w = 0;
				while (led == old_led && w < 200) begin
					@(negedge sys_clk);
					w++;
				end
				if (w >= 200) begin
					$display("timeout: led did not respond to key %0d", k);
					tb_errors++;
				end
				repeat (4) @(negedge sys_clk);
			end else begin
				repeat (48) @(negedge sys_clk);
			end
			key_idx = 2'(k);
			press_done = (phase == 0);
			release_done = (phase == 1);
			@(negedge sys_clk);
			press_done = 1'b0;
			release_done = 1'b0;
		end
	endtask

	// one mode-3 byte, sometimes cut short after 3 bits
	task automatic spi_xfer(input logic cut_short);
		logic [31:0] v;
		logic [7:0] tx, rx;
		int half;
		int nbits;
		take_bits(8, main_lfsr, v);
		tx = v[7:0];
		take_bits(2, main_lfsr, v);
		half = 6 + int'(v[1:0]);
		take_bits(3, main_lfsr, v);
		nbits = (cut_short || v[2:0] == 3'd0) ? 3 : 8;
		rx = 8'h00;
		cs = 1'b0;
		repeat (half) @(negedge sys_clk);
		for (int b = 0; b < nbits; b++) begin
			sclk = 1'b0;
			mosi = tx[7-b];
			repeat (half) @(negedge sys_clk);
			rx = {rx[6:0], miso};
			sclk = 1'b1;
			repeat (half) @(negedge sys_clk);
		end
		cs = 1'b1;
		spi_sent = tx;
		spi_got = rx;
		spi_abort = (nbits != 8);
		spi_done = 1'b1;
		@(negedge sys_clk);
		spi_done = 1'b0;
		take_bits(4, main_lfsr, v);
		repeat (4 + int'(v[3:0])) @(negedge sys_clk);
	endtask

	initial begin
		sys_rst_n = 1'b0;
		key_in = 4'hF;
		scl_in = 1'b1;
		cs = 1'b1;
		sclk = 1'b1;
		mosi = 1'b0;
		{press_done, release_done, spi_done, spi_abort} = 4'b0000;
		key_idx = 2'd0;
		spi_sent = 8'h00;
		spi_got = 8'h00;
		main_lfsr = SEED;
		tb_errors = 0;
		repeat (10) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (6) begin
			take_bits(2, main_lfsr, r);
			key_cycle(int'(r[1:0]));
		end
		for (int n = 0; n < 12; n++) begin
			spi_xfer(n == 5); // at least one aborted byte
		end
		t = 0;
		while (adc_count < 6 && t < 30000) begin
			@(negedge sys_clk);
			t++;
		end
		if (t >= 30000) begin
			$display("timeout: ADC model logged only %0d reads", adc_count);
			tb_errors++;
		end
		if (!withheld) begin
			$display("ADC model never withheld an address ACK");
			tb_errors++;
		end
		t = 0;
		do begin
			@(negedge sys_clk);
			t++;
		end while (busy && t < 1000);
		if (t >= 1000) begin
			$display("timeout: checker never finished its display scan");
			tb_errors++;
		end
		$display("checker errors: %0d, bench errors: %0d", errors, tb_errors);
		if (errors == 0 && tb_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
hw/board_pkg.sv
hw/display_pkg.sv
hw/i2c_adc_reader.sv
hw/adc_bcd_format.sv
hw/seg_scan.sv
hw/key_debounce.sv
hw/spi_slave.sv
hw/board_top.sv
bench/board_checker.sv
bench/board_tb.sv

/* hw/adc_bcd_format.sv */
/*
 * Turns each ADC byte into an eight-digit frame: dash on the left,
 * the value right-aligned without leading zeros, blanks in between.
 */
`timescale 1ns/10ps
`default_nettype none

module adc_bcd_format (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  board_pkg::adc_byte_t      sample,
	input  logic                      sample_vld,
	output display_pkg::digit_frame_t frame
);

	display_pkg::digit_code_t hund, tens, units;
	display_pkg::digit_frame_t frame_nx;

	always_comb begin
		hund = display_pkg::digit_code_t'(sample / 8'd100);
		tens = display_pkg::digit_code_t'((sample / 8'd10) % 8'd10);
		units = display_pkg::digit_code_t'(sample % 8'd10);
		frame_nx = {display_pkg::DIGIT_DASH,
			{(display_pkg::NUM_DIGITS - 1){display_pkg::DIGIT_BLANK}}};
		frame_nx[3:0] = units;
		if (sample >= 8'd10) begin
			frame_nx[7:4] = tens;
		end
		if (sample >= 8'd100) begin
			frame_nx[11:8] = hund;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frame <= {display_pkg::DIGIT_DASH,
				{(display_pkg::NUM_DIGITS - 1){display_pkg::DIGIT_BLANK}}};
		end else if (sample_vld) begin
			frame <= frame_nx; // latest sample wins
		end
	end

endmodule

`default_nettype wire

/* hw/board_pkg.sv */
/*
 * Board-level constants and byte types shared by the I2C ADC reader,
 * the key debouncer and the SPI slave. Timing is at simulation scale.
 */
`default_nettype none

package board_pkg;

	typedef logic [7:0] adc_byte_t; // one ADC sample
	typedef logic [7:0] spi_byte_t; // one SPI data byte

	// ADC on the I2C bus, channel 0 only
	localparam logic [6:0] ADC_DEV_ADDR = 7'h54;
	localparam adc_byte_t ADC_CTRL_BYTE = 8'h00;
	localparam int unsigned I2C_QUARTER = 4; // sys_clk cycles per quarter SCL

	localparam int unsigned NUM_KEYS = 4;
	localparam int unsigned DEBOUNCE_CYCLES = 32; // stable cycles before accept
	localparam int unsigned PRESS_CNT_W = 4;

	localparam int unsigned SPI_SYNC_STAGES = 3;
	localparam int unsigned SPI_REPLY_OFFSET = 2; // reply = last rx byte + this

endpackage

`default_nettype wire

/* hw/board_top.sv */
/*
 * Board demo top level: I2C ADC reading shown on the seven-segment
 * display, key-driven LEDs and an SPI slave. SDA is split into sda_oe/sda_in.
 */
`timescale 1ns/10ps
`default_nettype none

module board_top (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  logic [3:0]                key_in,     // active low
	input  logic                      scl_in,     // reserved for the pad wrapper
	input  logic                      sda_in,
	input  logic                      cs,
	input  logic                      sclk,
	input  logic                      mosi,
	output logic [7:0]                led,
	output display_pkg::seg_pattern_t seg_number,
	output logic [7:0]                seg_choice,
	output logic                      scl,
	output logic                      sda_oe,
	output logic                      miso
);

	board_pkg::adc_byte_t sample;
	logic sample_vld;
	display_pkg::digit_frame_t frame;

	i2c_adc_reader u_adc (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .sda_in(sda_in),
		.scl(scl), .sda_oe(sda_oe), .sample(sample), .sample_vld(sample_vld)
	);

	adc_bcd_format u_fmt (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .sample(sample),
		.sample_vld(sample_vld), .frame(frame)
	);

	seg_scan u_scan (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .frame(frame),
		.seg_number(seg_number), .seg_choice(seg_choice)
	);

	key_debounce u_keys (.sys_clk(sys_clk), .sys_rst_n(sys_rst_n), .key_in(key_in), .led(led));

	spi_slave u_spi (
		.sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
		.cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso)
	);

endmodule

`default_nettype wire

/* hw/display_pkg.sv */
/*
 * Seven-segment display definitions: digit codes, frame layout,
 * active-low glyph table and scan timing.
 */
`default_nettype none

package display_pkg;

	typedef logic [3:0] digit_code_t; // 0-9 decimal, others special
	typedef logic [31:0] digit_frame_t; // digit 0 in low nibble, rightmost
	typedef logic [7:0] seg_pattern_t; // active low, dp bit 7, seg a bit 0

	localparam digit_code_t DIGIT_BLANK = 4'd10;
	localparam digit_code_t DIGIT_DASH = 4'd15; // middle segment only
	localparam int unsigned NUM_DIGITS = 8;
	localparam int unsigned SCAN_CYCLES = 16; // cycles per digit slot

	// code to segment pattern
	localparam seg_pattern_t GLYPH [16] = '{
		8'hC0, 8'hF9, 8'hA4, 8'hB0, // 0..3
		8'h99, 8'h92, 8'h82, 8'hF8, // 4..7
		8'h80, 8'h90,               // 8, 9
		8'hFF, 8'hFF, 8'hFF,        // blank and unused codes
		8'hFF, 8'hFF,
		8'hBF                       // dash, seg g lit
	};

endpackage

`default_nettype wire

/* hw/i2c_adc_reader.sv */
/*
 * Free-running I2C master that reads the ADC control register over and over.
 * Each good read ends with STOP and a one-cycle sample_vld pulse; a missing
 * ACK ends the transaction early with no sample and the loop retries.
 */
`timescale 1ns/10ps
`default_nettype none

module i2c_adc_reader (
	input  logic                 sys_clk,
	input  logic                 sys_rst_n,
	input  logic                 sda_in,
	output logic                 scl,
	output logic                 sda_oe,     // high pulls SDA low
	output board_pkg::adc_byte_t sample,
	output logic                 sample_vld
);

	typedef enum logic [2:0] {
		ST_IDLE, ST_START, ST_WRITE, ST_ACK, ST_RESTART, ST_READ, ST_NACK, ST_STOP
	} i2c_state_t;

	i2c_state_t state;
	logic [7:0] q_cnt;
	logic [1:0] phase;    // quarter within a bit, scl high in 1 and 2
	logic [2:0] bit_cnt;
	logic [1:0] byte_idx; // 0 addr+W, 1 ctrl, 2 addr+R
	logic       ack_ok;
	logic       got_byte;
	logic       tick, bit_end, bit_hi;
	logic       scl_nx, oe_nx;
	logic [1:0] sda_sync;
	logic [7:0] tx_shift, rx_shift;

	assign tick = (q_cnt == 8'(board_pkg::I2C_QUARTER - 1));
	assign bit_end = tick && (phase == 2'd3);
	assign bit_hi = (phase == 2'd1) || (phase == 2'd2);

	always_comb begin
		scl_nx = 1'b1;
		oe_nx = 1'b0;
		case (state)
			ST_START: begin
				scl_nx = (phase != 2'd3);
				oe_nx = phase[1];      // sda falls while scl high
			end
			ST_RESTART: begin
				scl_nx = bit_hi;
				oe_nx = phase[1];
			end
			ST_WRITE: begin
				scl_nx = bit_hi;
				oe_nx = ~tx_shift[7];
			end
			ST_ACK, ST_READ, ST_NACK: scl_nx = bit_hi; // sda released
			ST_STOP: begin
				scl_nx = (phase != 2'd0);
				oe_nx = ~phase[1];     // sda rises while scl high
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= ST_IDLE;
			q_cnt <= '0;
			phase <= '0;
			bit_cnt <= '0;
			byte_idx <= '0;
			ack_ok <= 1'b0;
			got_byte <= 1'b0;
			sample_vld <= 1'b0;
			scl <= 1'b1;
			sda_oe <= 1'b0;
		end else begin
			scl <= scl_nx;
			sda_oe <= oe_nx;
			sample_vld <= 1'b0;
			q_cnt <= tick ? '0 : q_cnt + 8'd1;
			if (tick) begin
				phase <= phase + 2'd1;
			end
			if (tick && phase == 2'd1 && state == ST_ACK) begin
				ack_ok <= ~sda_sync[1];
			end
			if (bit_end) begin
				case (state)
					ST_IDLE: state <= ST_START; // one idle bit between reads
					ST_START: begin
						state <= ST_WRITE;
						byte_idx <= '0;
						got_byte <= 1'b0;
					end
					ST_WRITE: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) state <= ST_ACK;
					end
					ST_ACK: begin
						if (!ack_ok) begin
							state <= ST_STOP;   // no ACK, give up and retry
						end else if (byte_idx == 2'd2) begin
							state <= ST_READ;
						end else begin
							byte_idx <= byte_idx + 2'd1;
							state <= (byte_idx == 2'd1) ? ST_RESTART : ST_WRITE;
						end
					end
					ST_RESTART: state <= ST_WRITE;
					ST_READ: begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) state <= ST_NACK;
					end
					ST_NACK: begin
						got_byte <= 1'b1;
						state <= ST_STOP;
					end
					ST_STOP: begin
						sample_vld <= got_byte;
						state <= ST_IDLE;
					end
					default: state <= ST_IDLE;
				endcase
			end
		end
	end

	// data path, loaded before use
	always_ff @(posedge sys_clk) begin
		sda_sync <= {sda_sync[0], sda_in};
		if (bit_end) begin
			case (state)
				ST_START: tx_shift <= {board_pkg::ADC_DEV_ADDR, 1'b0};
				ST_ACK: tx_shift <= board_pkg::ADC_CTRL_BYTE;
				ST_RESTART: tx_shift <= {board_pkg::ADC_DEV_ADDR, 1'b1};
				ST_WRITE: tx_shift <= {tx_shift[6:0], 1'b0};
				default: ;
			endcase
		end
		if (tick && phase == 2'd1 && state == ST_READ) begin
			rx_shift <= {rx_shift[6:0], sda_sync[1]}; // mid scl high
		end
		if (bit_end && state == ST_NACK) begin
			sample <= rx_shift;
		end
	end

endmodule

`default_nettype wire

/* hw/key_debounce.sv */
/*
 * Debounces the four active-low push keys. Each accepted press toggles
 * its own LED in led[3:0] and bumps the shared counter in led[7:4].
 */
`timescale 1ns/10ps
`default_nettype none

module key_debounce (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [3:0] key_in,    // active low
	output logic [7:0] led
);

	logic [board_pkg::NUM_KEYS-1:0] key_meta, key_sync;
	logic [board_pkg::NUM_KEYS-1:0] key_lvl;  // debounced, 1 = released
	logic [board_pkg::NUM_KEYS-1:0] press;    // one-cycle accept pulse
	logic [board_pkg::NUM_KEYS-1:0] led_tog;
	logic [7:0] stab_cnt [board_pkg::NUM_KEYS];
	logic [board_pkg::PRESS_CNT_W-1:0] press_cnt, press_sum;

	always_comb begin
		press_sum = '0;
		for (int i = 0; i < board_pkg::NUM_KEYS; i++) begin
			press_sum = press_sum + {{(board_pkg::PRESS_CNT_W - 1){1'b0}}, press[i]};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
			key_lvl <= '1;
			press <= '0;
			led_tog <= '0;
			press_cnt <= '0;
			for (int i = 0; i < board_pkg::NUM_KEYS; i++) begin
				stab_cnt[i] <= '0;
			end
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
			for (int i = 0; i < board_pkg::NUM_KEYS; i++) begin
				press[i] <= 1'b0;
				if (key_sync[i] == key_lvl[i]) begin
					stab_cnt[i] <= '0;   // bounce restarts the count
				end else if (stab_cnt[i] == 8'(board_pkg::DEBOUNCE_CYCLES - 1)) begin
					stab_cnt[i] <= '0;
					key_lvl[i] <= key_sync[i];
					press[i] <= ~key_sync[i]; // release gives no pulse
				end else begin
					stab_cnt[i] <= stab_cnt[i] + 8'd1;
				end
			end
			led_tog <= led_tog ^ press;
			press_cnt <= press_cnt + press_sum; // wraps
		end
	end

	assign led = {press_cnt, led_tog};

endmodule

`default_nettype wire

/* hw/seg_scan.sv */
/*
 * Seven-segment scanner. Steps through the eight digits of the frame,
 * one every SCAN_CYCLES, and drives the glyph with its active-low select.
 */
`timescale 1ns/10ps
`default_nettype none

module seg_scan (
	input  logic                      sys_clk,
	input  logic                      sys_rst_n,
	input  display_pkg::digit_frame_t frame,
	output display_pkg::seg_pattern_t seg_number,
	output logic [7:0]                seg_choice  // active-low one-hot
);

	logic [7:0] slot_cnt;
	logic [2:0] digit_idx;
	logic       slot_end;
	display_pkg::digit_code_t code;

	assign slot_end = (slot_cnt == 8'(display_pkg::SCAN_CYCLES - 1));
	assign code = frame[{digit_idx, 2'b00} +: 4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			slot_cnt <= '0;
			digit_idx <= '0;
			seg_choice <= 8'hFE;  // digit 0
			seg_number <= 8'hFF;
		end else begin
			slot_cnt <= slot_end ? '0 : slot_cnt + 8'd1;
			if (slot_end) begin
				if (digit_idx == 3'(display_pkg::NUM_DIGITS - 1)) begin
					digit_idx <= '0;
				end else begin
					digit_idx <= digit_idx + 3'd1;
				end
			end
			// pattern and select change on the same edge
			seg_choice <= ~(8'd1 << digit_idx);
			seg_number <= display_pkg::GLYPH[code];
		end
	end

endmodule

`default_nettype wire

/* hw/spi_slave.sv */
/*
 * SPI mode-3 slave, MSB first. Pins are synchronised to sys_clk; each
 * finished byte sets the next reply to that byte plus the reply offset.
 */
`timescale 1ns/10ps
`default_nettype none

module spi_slave (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs,        // active low
	input  logic sclk,
	input  logic mosi,
	output logic miso
);

	logic [board_pkg::SPI_SYNC_STAGES-1:0] cs_sync, sclk_sync, mosi_sync;
	logic cs_s, sclk_s, mosi_s;
	logic cs_d, sclk_d;
	logic cs_fall, sclk_rise, sclk_fall;
	logic [2:0] bit_cnt;
	board_pkg::spi_byte_t rx_shift, tx_shift, rx_byte, reply, reply_nx;

	assign cs_s = cs_sync[board_pkg::SPI_SYNC_STAGES-1];
	assign sclk_s = sclk_sync[board_pkg::SPI_SYNC_STAGES-1];
	assign mosi_s = mosi_sync[board_pkg::SPI_SYNC_STAGES-1];
	assign cs_fall = ~cs_s & cs_d;
	assign sclk_rise = ~cs_s & sclk_s & ~sclk_d; // sample edge
	assign sclk_fall = ~cs_s & ~sclk_s & sclk_d; // shift edge
	assign rx_byte = {rx_shift[6:0], mosi_s};
	assign reply_nx = rx_byte + board_pkg::spi_byte_t'(board_pkg::SPI_REPLY_OFFSET);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cs_sync <= '1;
			sclk_sync <= '1;     // mode 3 idles high
			mosi_sync <= '0;
			cs_d <= 1'b1;
			sclk_d <= 1'b1;
			bit_cnt <= '0;
			reply <= board_pkg::spi_byte_t'(board_pkg::SPI_REPLY_OFFSET);
			miso <= 1'b1;
		end else begin
			cs_sync <= {cs_sync[board_pkg::SPI_SYNC_STAGES-2:0], cs};
			sclk_sync <= {sclk_sync[board_pkg::SPI_SYNC_STAGES-2:0], sclk};
			mosi_sync <= {mosi_sync[board_pkg::SPI_SYNC_STAGES-2:0], mosi};
			cs_d <= cs_s;
			sclk_d <= sclk_s;
			if (cs_s) begin
				bit_cnt <= '0;     // partial byte dropped
				miso <= 1'b1;
			end else begin
				if (cs_fall) begin
					miso <= reply[7];
				end else if (sclk_fall) begin
					miso <= tx_shift[7];
				end
				if (sclk_rise) begin
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt == 3'd7) reply <= reply_nx;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (cs_fall) begin
			tx_shift <= reply;
		end else if (sclk_rise) begin
			tx_shift <= (bit_cnt == 3'd7) ? reply_nx : {tx_shift[6:0], 1'b1};
		end
		if (sclk_rise) begin
			rx_shift <= rx_byte;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator and run; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module board_tb -o board_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "compile failed"
	exit 1
fi

./obj_dir/board_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
